//--- all.f
hw/flight_pkg.sv
hw/timing_pkg.sv
hw/us_tick.sv
hw/receiver.sv
hw/angle_controller.sv
hw/body_frame_controller.sv
hw/motor_mixer.sv
hw/pwm_generator.sv
hw/drone_core.sv
sim/tb_drone_core.sv

//--- hw/angle_controller.sv
/* Angle controller */

`timescale 1ns/100ps

module angle_controller import flight_pkg::*; (
    input  logic        sys_clk,
    input  logic        resetn,
    input  logic        start,
    input  rc_values_t  rc,
    input  imu_sample_t imu,
    output axis_rates_t target,
    output logic        done
);

    logic signed [RATE_WIDTH-1:0] yaw_stick;
    logic signed [RATE_WIDTH-1:0] roll_stick;
    logic signed [RATE_WIDTH-1:0] pitch_stick;

    // Sticks relative to center give angles, or yaw rate for the yaw stick
    always_comb begin
        yaw_stick   = RATE_WIDTH'(rc.yaw) - RATE_WIDTH'(STICK_CENTER);
        roll_stick  = RATE_WIDTH'(rc.roll) - RATE_WIDTH'(STICK_CENTER);
        pitch_stick = RATE_WIDTH'(rc.pitch) - RATE_WIDTH'(STICK_CENTER);
    end

    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            target <= '0;
            done   <= 1'b0;
        end else begin
            // Result and strobe in the cycle after start
            done <= start;
            if (start) begin
                // Target rate is angle error, then minus measured rate
                target.roll     <= roll_stick - imu.roll_angle - imu.roll_rate;
                target.pitch    <= pitch_stick - imu.pitch_angle - imu.pitch_rate;
                // Yaw stick commands a rate directly
                target.yaw      <= yaw_stick - imu.yaw_rate;
                target.throttle <= rc.throttle;
            end
        end
    end

endmodule

//--- hw/body_frame_controller.sv
/* Body-frame rate controller */

`timescale 1ns/100ps

module body_frame_controller import flight_pkg::*; (
    input  logic        sys_clk,
    input  logic        resetn,
    input  logic        start,
    input  axis_rates_t target,
    output axis_rates_t correction,
    output logic        done
);

    // Proportional gain as arithmetic shift, then symmetric clip
    function automatic logic signed [RATE_WIDTH-1:0] gain_sat(
        input logic signed [RATE_WIDTH-1:0] err
    );
        logic signed [RATE_WIDTH-1:0] scaled;
        scaled = err >>> RATE_SHIFT;
        if (scaled > RATE_LIMIT) begin
            return RATE_WIDTH'(RATE_LIMIT);
        end else if (scaled < -RATE_LIMIT) begin
            return -RATE_WIDTH'(RATE_LIMIT);
        end else begin
            return scaled;
        end
    endfunction

    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            correction <= '0;
            done       <= 1'b0;
        end else begin
            done <= start;
            if (start) begin
                // Axis fields arrive as rate errors
                correction.yaw      <= gain_sat(target.yaw);
                correction.roll     <= gain_sat(target.roll);
                correction.pitch    <= gain_sat(target.pitch);
                correction.throttle <= target.throttle;
            end
        end
    end

endmodule

//--- hw/drone_core.sv
/* Flight control core */

`timescale 1ns/100ps

module drone_core import flight_pkg::*; (
    input  logic         sys_clk,
    input  logic         resetn,
    input  logic         throttle_pwm,
    input  logic         yaw_pwm,
    input  logic         roll_pwm,
    input  logic         pitch_pwm,
    input  logic         imu_valid,
    input  imu_sample_t  imu,
    output logic         motor_1_pwm,
    output logic         motor_2_pwm,
    output logic         motor_3_pwm,
    output logic         motor_4_pwm,
    output motor_rates_t motor_rates,
    output logic         mix_valid
);

    logic        tick_us;
    rc_values_t  rc;
    axis_rates_t target;
    logic        ac_done;
    axis_rates_t correction;
    logic        bf_done;

    // Microsecond enable for receiver and PWM
    us_tick u_us_tick (
        .sys_clk (sys_clk),
        .resetn  (resetn),
        .tick_us (tick_us)
    );

    receiver u_receiver (
        .sys_clk      (sys_clk),
        .resetn       (resetn),
        .tick_us      (tick_us),
        .throttle_pwm (throttle_pwm),
        .yaw_pwm      (yaw_pwm),
        .roll_pwm     (roll_pwm),
        .pitch_pwm    (pitch_pwm),
        .rc           (rc)
    );

    // Chain runs one stage per cycle from imu_valid
    angle_controller u_angle_controller (
        .sys_clk (sys_clk),
        .resetn  (resetn),
        .start   (imu_valid),
        .rc      (rc),
        .imu     (imu),
        .target  (target),
        .done    (ac_done)
    );

    body_frame_controller u_body_frame_controller (
        .sys_clk    (sys_clk),
        .resetn     (resetn),
        .start      (ac_done),
        .target     (target),
        .correction (correction),
        .done       (bf_done)
    );

    motor_mixer u_motor_mixer (
        .sys_clk     (sys_clk),
        .resetn      (resetn),
        .start       (bf_done),
        .correction  (correction),
        .motor_rates (motor_rates),
        .mix_valid   (mix_valid)
    );

    pwm_generator u_pwm_generator (
        .sys_clk     (sys_clk),
        .resetn      (resetn),
        .tick_us     (tick_us),
        .motor_rates (motor_rates),
        .motor_1_pwm (motor_1_pwm),
        .motor_2_pwm (motor_2_pwm),
        .motor_3_pwm (motor_3_pwm),
        .motor_4_pwm (motor_4_pwm)
    );

endmodule

//--- hw/flight_pkg.sv
/* Flight datapath types and constants */

package flight_pkg;

    // Stick values and motor rates
    localparam int REC_VAL_WIDTH = 8;
    // Signed angles, rates and errors
    localparam int RATE_WIDTH    = 16;

    // Stick value meaning zero angle or zero yaw rate
    localparam int STICK_CENTER  = 125;
    // Proportional rate gain as a right shift
    localparam int RATE_SHIFT    = 2;
    // Symmetric limit on body-frame corrections
    localparam int RATE_LIMIT    = 63;
    localparam int MOTOR_MAX     = 250;
    // Below this throttle the motors idle at zero
    localparam int ARM_THRESHOLD = 10;

    typedef struct packed {
        logic [REC_VAL_WIDTH-1:0] throttle;
        logic [REC_VAL_WIDTH-1:0] yaw;
        logic [REC_VAL_WIDTH-1:0] roll;
        logic [REC_VAL_WIDTH-1:0] pitch;
    } rc_values_t;

    typedef struct packed {
        logic signed [RATE_WIDTH-1:0] roll_angle;
        logic signed [RATE_WIDTH-1:0] pitch_angle;
        logic signed [RATE_WIDTH-1:0] roll_rate;
        logic signed [RATE_WIDTH-1:0] pitch_rate;
        logic signed [RATE_WIDTH-1:0] yaw_rate;
    } imu_sample_t;

    typedef struct packed {
        logic signed [RATE_WIDTH-1:0] yaw;
        logic signed [RATE_WIDTH-1:0] roll;
        logic signed [RATE_WIDTH-1:0] pitch;
        logic [REC_VAL_WIDTH-1:0]     throttle;
    } axis_rates_t;

    typedef struct packed {
        logic [REC_VAL_WIDTH-1:0] m1;
        logic [REC_VAL_WIDTH-1:0] m2;
        logic [REC_VAL_WIDTH-1:0] m3;
        logic [REC_VAL_WIDTH-1:0] m4;
    } motor_rates_t;

endpackage

//--- hw/motor_mixer.sv
/* Quad-X motor mixer */

`timescale 1ns/100ps

module motor_mixer import flight_pkg::*; (
    input  logic         sys_clk,
    input  logic         resetn,
    input  logic         start,
    input  axis_rates_t  correction,
    output motor_rates_t motor_rates,
    output logic         mix_valid
);

    // Two guard bits for sums of four terms
    logic signed [RATE_WIDTH+1:0] t;
    logic signed [RATE_WIDTH+1:0] p;
    logic signed [RATE_WIDTH+1:0] r;
    logic signed [RATE_WIDTH+1:0] y;
    logic                         armed;

    function automatic logic [REC_VAL_WIDTH-1:0] clamp(input logic signed [RATE_WIDTH+1:0] v);
        if (v < 0) begin
            return '0;
        end else if (v > MOTOR_MAX) begin
            return REC_VAL_WIDTH'(MOTOR_MAX);
        end else begin
            return v[REC_VAL_WIDTH-1:0];
        end
    endfunction

    always_comb begin
        t     = {{(RATE_WIDTH+2-REC_VAL_WIDTH){1'b0}}, correction.throttle};
        p     = {{2{correction.pitch[RATE_WIDTH-1]}}, correction.pitch};
        r     = {{2{correction.roll[RATE_WIDTH-1]}}, correction.roll};
        y     = {{2{correction.yaw[RATE_WIDTH-1]}}, correction.yaw};
        armed = (correction.throttle >= ARM_THRESHOLD);
    end

    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            motor_rates <= '0;
            mix_valid   <= 1'b0;
        end else begin
            mix_valid <= start;
            if (start) begin
                // Idle cutoff below arming throttle
                if (!armed) begin
                    motor_rates <= '0;
                end else begin
                    motor_rates.m1 <= clamp(t + p + r - y);
                    motor_rates.m2 <= clamp(t + p - r + y);
                    motor_rates.m3 <= clamp(t - p - r - y);
                    motor_rates.m4 <= clamp(t - p + r + y);
                end
            end
        end
    end

endmodule

//--- hw/pwm_generator.sv
/* ESC pulse generator */

`timescale 1ns/100ps

module pwm_generator import flight_pkg::*, timing_pkg::*; (
    input  logic         sys_clk,
    input  logic         resetn,
    input  logic         tick_us,
    input  motor_rates_t motor_rates,
    output logic         motor_1_pwm,
    output logic         motor_2_pwm,
    output logic         motor_3_pwm,
    output logic         motor_4_pwm
);

    logic [US_CNT_WIDTH-1:0]       frame_cnt;
    // Index 3 holds motor 1
    logic [3:0][REC_VAL_WIDTH-1:0] rates_q;
    logic [3:0]                    pwm_q;

    // High time in us for a given rate
    function automatic logic [US_CNT_WIDTH-1:0] pulse_width(input logic [REC_VAL_WIDTH-1:0] rate);
        return US_CNT_WIDTH'(PULSE_MIN_US + US_PER_STEP * rate);
    endfunction

    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            frame_cnt <= '0;
            rates_q   <= '0;
            pwm_q     <= '0;
        end else begin
            if (tick_us) begin
                // Frame wrap takes the newest rates
                if (frame_cnt == PWM_PERIOD_US - 1) begin
                    frame_cnt <= '0;
                    rates_q   <= motor_rates;
                end else begin
                    frame_cnt <= frame_cnt + 1'b1;
                end
            end
            // High from frame start until the width is reached
            for (int i = 0; i < 4; i++) begin
                pwm_q[i] <= (frame_cnt < pulse_width(rates_q[i]));
            end
        end
    end

    assign motor_1_pwm = pwm_q[3];
    assign motor_2_pwm = pwm_q[2];
    assign motor_3_pwm = pwm_q[1];
    assign motor_4_pwm = pwm_q[0];

endmodule

//--- hw/receiver.sv
/* RC receiver pulse measurement */

`timescale 1ns/100ps

module receiver import flight_pkg::*, timing_pkg::*; (
    input  logic       sys_clk,
    input  logic       resetn,
    input  logic       tick_us,
    input  logic       throttle_pwm,
    input  logic       yaw_pwm,
    input  logic       roll_pwm,
    input  logic       pitch_pwm,
    output rc_values_t rc
);

    // Channel 3 is throttle, down to channel 0 for pitch
    logic [3:0]                         pwm_in;
    logic [3:0]                         sync1;
    logic [3:0]                         sync2;
    logic [3:0]                         prev;
    logic [3:0][US_CNT_WIDTH-1:0]       width_cnt;
    logic [3:0][REC_VAL_WIDTH-1:0]      val;

    // Width in us to stick value, saturating at both ends
    function automatic logic [REC_VAL_WIDTH-1:0] to_value(input logic [US_CNT_WIDTH-1:0] w);
        if (w < PULSE_MIN_US) begin
            return '0;
        end else if (w > PULSE_MAX_US) begin
            return REC_VAL_WIDTH'((PULSE_MAX_US - PULSE_MIN_US) / US_PER_STEP);
        end else begin
            return REC_VAL_WIDTH'((w - PULSE_MIN_US) / US_PER_STEP);
        end
    endfunction

    assign pwm_in = {throttle_pwm, yaw_pwm, roll_pwm, pitch_pwm};

    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            sync1     <= '0;
            sync2     <= '0;
            prev      <= '0;
            width_cnt <= '0;
            val       <= '0;
        end else begin
            // Two-flop synchronizer, third flop for edge detect
            sync1 <= pwm_in;
            sync2 <= sync1;
            prev  <= sync2;
            for (int i = 0; i < 4; i++) begin
                // Rising edge restarts the measurement
                if (sync2[i] && !prev[i]) begin
                    width_cnt[i] <= '0;
                end else if (sync2[i] && tick_us && width_cnt[i] != '1) begin
                    width_cnt[i] <= width_cnt[i] + 1'b1;
                end
                // Falling edge stores the converted width
                if (!sync2[i] && prev[i]) begin
                    val[i] <= to_value(width_cnt[i]);
                end
            end
        end
    end

    // Throttle lands in the top field
    assign rc = rc_values_t'(val);

endmodule

//--- hw/timing_pkg.sv
/* Pulse timing constants */

package timing_pkg;

    // sys_clk at 125 MHz
    localparam int TICKS_PER_US  = 125;
    localparam int PULSE_MIN_US  = 1000;
    localparam int PULSE_MAX_US  = 2000;
    // ESC frame length
    localparam int PWM_PERIOD_US = 2500;
    // Microseconds per unit of stick value or motor rate
    localparam int US_PER_STEP   = 4;
    // Microsecond counters, wide enough for a full frame
    localparam int US_CNT_WIDTH  = 12;

endpackage

//--- hw/us_tick.sv
/* Microsecond tick */

`timescale 1ns/100ps

module us_tick import timing_pkg::*; (
    input  logic sys_clk,
    input  logic resetn,
    output logic tick_us
);

    logic [$clog2(TICKS_PER_US)-1:0] cnt;

    // Free-running count of sys_clk cycles within one microsecond
    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            cnt <= '0;
        end else if (cnt == TICKS_PER_US - 1) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // One-cycle strobe at wrap
    assign tick_us = (cnt == TICKS_PER_US - 1);

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run with Verilator, then decide the result from the simulation log
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_drone_core -f all.f \
    -o tb_drone_core > build.log 2>&1 \
    && ./obj_dir/tb_drone_core > sim.log 2>&1 \
    || echo "build or simulation stopped early, see build.log and sim.log"
grep -q "^sim passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- sim/tb_drone_core.sv
/* Flight control core testbench */

`timescale 1ns/100ps

module tb_drone_core import flight_pkg::*, timing_pkg::*; ();

    localparam int FRAME_CYCLES = PWM_PERIOD_US * TICKS_PER_US;
    // Centered stick at mid step so the tick phase cannot move the value
    localparam int CENTER_US    = PULSE_MIN_US + US_PER_STEP * STICK_CENTER + 2;
    // Run length bound from pulse trains of under 3 ms and PWM frames
    localparam int PULSE_ROUNDS = 8;
    localparam int PWM_FRAMES   = 8;
    localparam int WATCHDOG_US  = PULSE_ROUNDS * 3000 + PWM_FRAMES * PWM_PERIOD_US;
    localparam int MIX_TIMEOUT  = 16;

    logic         sys_clk;
    logic         resetn;
    logic         throttle_pwm;
    logic         yaw_pwm;
    logic         roll_pwm;
    logic         pitch_pwm;
    logic         imu_valid;
    imu_sample_t  imu;
    logic         motor_1_pwm;
    logic         motor_2_pwm;
    logic         motor_3_pwm;
    logic         motor_4_pwm;
    motor_rates_t motor_rates;
    logic         mix_valid;
    integer       seed;
    // Stick values the receiver should hold after the last pulse train
    rc_values_t   exp_rc;

    drone_core u_drone_core (
        .sys_clk      (sys_clk),
        .resetn       (resetn),
        .throttle_pwm (throttle_pwm),
        .yaw_pwm      (yaw_pwm),
        .roll_pwm     (roll_pwm),
        .pitch_pwm    (pitch_pwm),
        .imu_valid    (imu_valid),
        .imu          (imu),
        .motor_1_pwm  (motor_1_pwm),
        .motor_2_pwm  (motor_2_pwm),
        .motor_3_pwm  (motor_3_pwm),
        .motor_4_pwm  (motor_4_pwm),
        .motor_rates  (motor_rates),
        .mix_valid    (mix_valid)
    );

    // 125 MHz
    initial begin
        sys_clk = 1'b0;
        forever #4 sys_clk = ~sys_clk;
    end

    task automatic stop_with_error(input string line);
        $display("%s", line);
        $display("sim failed");
        $fatal(1);
    endtask

    initial begin
        #(WATCHDOG_US * 1000);
        stop_with_error("Watchdog expired before the tests finished");
    end

    // Pulse width in us to stick value
    function automatic int stick_value(input int w);
        if (w < PULSE_MIN_US) begin
            return 0;
        end else if (w > PULSE_MAX_US) begin
            return (PULSE_MAX_US - PULSE_MIN_US) / US_PER_STEP;
        end
        return (w - PULSE_MIN_US) / US_PER_STEP;
    endfunction

    function automatic int random_width();
        int sel;
        int r;
        sel = ($random(seed) & 32'h7fff_ffff) % 10;
        r   = $random(seed) & 32'h7fff_ffff;
        // Some pulses below and above the valid range
        if (sel == 0) begin
            return 600 + r % 390;
        end else if (sel == 1) begin
            return 2010 + r % 300;
        end
        return PULSE_MIN_US + US_PER_STEP * (r % 250) + 2;
    endfunction

    function automatic imu_sample_t random_sample(input int range);
        imu_sample_t s;
        s.roll_angle  = RATE_WIDTH'($random(seed) % range);
        s.pitch_angle = RATE_WIDTH'($random(seed) % range);
        s.roll_rate   = RATE_WIDTH'($random(seed) % range);
        s.pitch_rate  = RATE_WIDTH'($random(seed) % range);
        s.yaw_rate    = RATE_WIDTH'($random(seed) % range);
        return s;
    endfunction

    // Proportional gain then symmetric saturation
    function automatic int gain_limit(input int e);
        int v;
        v = e >>> RATE_SHIFT;
        if (v > RATE_LIMIT) begin
            return RATE_LIMIT;
        end else if (v < -RATE_LIMIT) begin
            return -RATE_LIMIT;
        end
        return v;
    endfunction

    function automatic logic [REC_VAL_WIDTH-1:0] clamp_motor(input int v);
        if (v < 0) begin
            return '0;
        end else if (v > MOTOR_MAX) begin
            return REC_VAL_WIDTH'(MOTOR_MAX);
        end
        return REC_VAL_WIDTH'(v);
    endfunction

    // Reference model of the whole control chain
    function automatic motor_rates_t expected_motors(input rc_values_t rc, input imu_sample_t s);
        int y;
        int r;
        int p;
        int t;
        motor_rates_t m;
        // Stick angle minus measured angle minus measured rate
        y = gain_limit(int'(rc.yaw) - STICK_CENTER - int'(s.yaw_rate));
        r = gain_limit(int'(rc.roll) - STICK_CENTER - int'(s.roll_angle) - int'(s.roll_rate));
        p = gain_limit(int'(rc.pitch) - STICK_CENTER - int'(s.pitch_angle) - int'(s.pitch_rate));
        t = int'(rc.throttle);
        m.m1 = clamp_motor(t + p + r - y);
        m.m2 = clamp_motor(t + p - r + y);
        m.m3 = clamp_motor(t - p - r - y);
        m.m4 = clamp_motor(t - p + r + y);
        // Idle cutoff
        if (t < ARM_THRESHOLD) begin
            m = '0;
        end
        return m;
    endfunction

    // All four channels rise together and each falls after its own width
    task automatic drive_rc_pulses(input int wt, input int wy, input int wr, input int wp);
        int last;
        int c;
        last = (wt > wy) ? wt : wy;
        last = (last > wr) ? last : wr;
        last = (last > wp) ? last : wp;
        for (c = 0; c <= last * TICKS_PER_US; c++) begin
            @(posedge sys_clk);
            throttle_pwm <= (c < wt * TICKS_PER_US);
            yaw_pwm      <= (c < wy * TICKS_PER_US);
            roll_pwm     <= (c < wr * TICKS_PER_US);
            pitch_pwm    <= (c < wp * TICKS_PER_US);
        end
        // Falling edge still crossing the synchronizer
        repeat (8) @(posedge sys_clk);
        exp_rc.throttle = REC_VAL_WIDTH'(stick_value(wt));
        exp_rc.yaw      = REC_VAL_WIDTH'(stick_value(wy));
        exp_rc.roll     = REC_VAL_WIDTH'(stick_value(wr));
        exp_rc.pitch    = REC_VAL_WIDTH'(stick_value(wp));
    endtask

    task automatic send_imu(input imu_sample_t s);
        @(posedge sys_clk);
        imu       <= s;
        imu_valid <= 1'b1;
        @(posedge sys_clk);
        imu_valid <= 1'b0;
    endtask

    // Cycles counted from the edge that took imu_valid
    task automatic wait_mix_result(output int lat);
        lat = 0;
        do begin
            @(negedge sys_clk);
            lat++;
        end while (!mix_valid && lat < MIX_TIMEOUT);
        assert (mix_valid) else stop_with_error("mix_valid never rose after the IMU strobe");
    endtask

    task automatic check_motor_rates(input motor_rates_t exp, input string tag);
        logic [3:0][REC_VAL_WIDTH-1:0] got;
        logic [3:0][REC_VAL_WIDTH-1:0] want;
        int i;
        got  = motor_rates;
        want = exp;
        // Index 3 is motor 1
        for (i = 3; i >= 0; i--) begin
            assert (got[i] == want[i]) else stop_with_error($sformatf(
                "Mismatch at %0t: %s m%0d is %0d, expected %0d",
                $time, tag, 4 - i, got[i], want[i]));
        end
    endtask

    task automatic run_sample(input imu_sample_t s, input string tag);
        int lat;
        send_imu(s);
        wait_mix_result(lat);
        assert (lat == 3) else stop_with_error($sformatf(
            "Mismatch at %0t: %s latency %0d cycles, expected 3", $time, tag, lat));
        check_motor_rates(expected_motors(exp_rc, s), tag);
    endtask

    // High time of each output over one full frame
    task automatic measure_pwm_frame(input motor_rates_t exp);
        logic [3:0][REC_VAL_WIDTH-1:0] want;
        logic [3:0] pins;
        logic       prev;
        int         hi [4];
        int         waited;
        int         c;
        int         i;
        want   = exp;
        prev   = motor_1_pwm;
        waited = 0;
        for (i = 0; i < 4; i++) begin
            hi[i] = 0;
        end
        // Frame start is the rising edge of motor 1
        while (1) begin
            @(negedge sys_clk);
            if (motor_1_pwm && !prev) begin
                break;
            end
            prev = motor_1_pwm;
            waited++;
            assert (waited < 2 * FRAME_CYCLES) else
                stop_with_error("No PWM frame start within two frames");
        end
        for (c = 0; c < FRAME_CYCLES; c++) begin
            if (c > 0) begin
                @(negedge sys_clk);
            end
            pins = {motor_1_pwm, motor_2_pwm, motor_3_pwm, motor_4_pwm};
            for (i = 0; i < 4; i++) begin
                hi[i] += int'(pins[i]);
            end
        end
        for (i = 3; i >= 0; i--) begin
            assert (hi[i] == (PULSE_MIN_US + US_PER_STEP * int'(want[i])) * TICKS_PER_US)
                else stop_with_error($sformatf(
                    "Mismatch at %0t: motor_%0d_pwm high %0d us, expected %0d us", $time,
                    4 - i, hi[i] / TICKS_PER_US, PULSE_MIN_US + US_PER_STEP * int'(want[i])));
        end
    endtask

    task automatic reset_state();
        int c;
        for (c = 0; c < 64; c++) begin
            @(negedge sys_clk);
            assert (!mix_valid) else
                stop_with_error($sformatf("Mismatch at %0t: mix_valid high after reset", $time));
            assert (motor_rates == '0) else
                stop_with_error($sformatf("Mismatch at %0t: motor_rates not zero", $time));
        end
        measure_pwm_frame('0);
    endtask

    task automatic receiver_conversion();
        int k;
        for (k = 0; k < 4; k++) begin
            drive_rc_pulses(random_width(), random_width(), random_width(), random_width());
            run_sample('0, "receiver");
        end
        // Widths past both ends of the pulse range
        drive_rc_pulses(2150, 800, 2400, CENTER_US);
        run_sample('0, "receiver limits");
        // Throttle under the arming threshold inside and below the pulse range
        drive_rc_pulses(PULSE_MIN_US + US_PER_STEP * 5 + 2, random_width(), 1302, 1702);
        run_sample('0, "idle cutoff");
        check_motor_rates('0, "idle cutoff");
        drive_rc_pulses(900, 1702, random_width(), 1202);
        run_sample(random_sample(300), "idle cutoff");
        check_motor_rates('0, "idle cutoff");
    endtask

    task automatic control_loops();
        imu_sample_t s;
        int          k;
        drive_rc_pulses(CENTER_US, CENTER_US, CENTER_US, CENTER_US);
        // Small samples stay linear and large ones saturate and clamp
        for (k = 0; k < 12; k++) begin
            run_sample(random_sample((k % 2 == 0) ? 100 : 700), "rate loop");
        end
        // Roll error alone well past the rate limit
        s            = '0;
        s.roll_angle = RATE_WIDTH'(-400);
        run_sample(s, "rate limit");
        // Roll and pitch together drive motor 1 to 250 and motor 3 to 0
        s.pitch_angle = RATE_WIDTH'(-400);
        run_sample(s, "motor clamp");
    endtask

    task automatic back_to_back_samples();
        imu_sample_t s [3];
        int          lat;
        int          k;
        for (k = 0; k < 3; k++) begin
            s[k] = random_sample(300);
        end
        for (k = 0; k < 3; k++) begin
            @(posedge sys_clk);
            imu       <= s[k];
            imu_valid <= 1'b1;
        end
        @(posedge sys_clk);
        imu_valid <= 1'b0;
        // First result lands on the edge that drops imu_valid
        wait_mix_result(lat);
        assert (lat == 1) else stop_with_error($sformatf(
            "Mismatch at %0t: first pipelined result late by %0d cycles", $time, lat - 1));
        check_motor_rates(expected_motors(exp_rc, s[0]), "pipeline 0");
        for (k = 1; k < 3; k++) begin
            @(negedge sys_clk);
            assert (mix_valid) else stop_with_error($sformatf(
                "Mismatch at %0t: mix_valid low for pipelined sample %0d", $time, k));
            check_motor_rates(expected_motors(exp_rc, s[k]), $sformatf("pipeline %0d", k));
        end
        @(negedge sys_clk);
        assert (!mix_valid) else
            stop_with_error($sformatf("Mismatch at %0t: extra mix_valid pulse", $time));
    endtask

    task automatic pwm_widths();
        imu_sample_t s;
        s = random_sample(100);
        run_sample(s, "pwm");
        measure_pwm_frame(expected_motors(exp_rc, s));
    endtask

    initial begin
        seed         = 32'h5500;
        resetn       = 1'b0;
        throttle_pwm = 1'b0;
        yaw_pwm      = 1'b0;
        roll_pwm     = 1'b0;
        pitch_pwm    = 1'b0;
        imu_valid    = 1'b0;
        imu          = '0;
        exp_rc       = '0;
        repeat (3) @(posedge sys_clk);
        resetn <= 1'b1;
        reset_state();
        receiver_conversion();
        control_loops();
        back_to_back_samples();
        pwm_widths();
        $display("sim passed");
        $finish;
    end

endmodule
